/* rtl/morse_pkg.sv */
package morse_pkg;

   // message geometry
   parameter int CHAR_W          = 6;
   parameter int NUM_CHARS       = 8;
   parameter int ELEMS_PER_CHAR  = 5;
   parameter int SLOTS_PER_ELEM  = 5;
   parameter int GAP_SLOTS       = 5;

   parameter int SLOTS_PER_CHAR  = GAP_SLOTS + ELEMS_PER_CHAR * SLOTS_PER_ELEM; // 30

   // index widths for the sequencer counters
   parameter int CHAR_IDX_W      = $clog2(NUM_CHARS);
   parameter int SLOT_IDX_W      = $clog2(SLOTS_PER_CHAR);
   parameter int ELEM_IDX_W      = $clog2(ELEMS_PER_CHAR);
   parameter int SUB_IDX_W       = $clog2(SLOTS_PER_ELEM);

   // dot and dash on-slots within an element
   parameter int DOT_ON_SLOTS    = 1;
   parameter int DASH_ON_SLOTS   = 3;

   // timing defaults for a 50 MHz clock
   parameter int DEFAULT_SLOT_CYCLES = 25000000; // 500 ms per slot
   parameter int DEFAULT_HALF_PERIOD = 37919;    // roughly 659 Hz tone

   typedef logic [CHAR_W-1:0] char_code_t;

   // element bit set means dash, element 0 in bit 0
   typedef struct packed {
      logic                      valid;
      logic [ELEMS_PER_CHAR-1:0] elems;
   } morse_pattern_t;

endpackage

/* rtl/morse_char_rom.sv */
`timescale 1ns/1ps

module morse_char_rom (
   input  morse_pkg::char_code_t     code,
   output morse_pkg::morse_pattern_t pattern
);

   import morse_pkg::*;

   logic                      hit;
   logic [ELEMS_PER_CHAR-1:0] elems;

   // digits 0 to 9, first element in bit 0
   always_comb begin
      hit = 1'b1;
      case (code)
         6'd36:   elems = 5'b11111; // -----
         6'd27:   elems = 5'b11110; // .----
         6'd28:   elems = 5'b11100; // ..---
         6'd29:   elems = 5'b11000; // ...--
         6'd30:   elems = 5'b10000; // ....-
         6'd31:   elems = 5'b00000; // .....
         6'd35:   elems = 5'b00001; // -....
         6'd34:   elems = 5'b00011; // --...
         6'd33:   elems = 5'b00111; // ---..
         6'd32:   elems = 5'b01111; // ----.
         default: begin
            hit   = 1'b0;
            elems = '0;
         end
      endcase
   end

   assign pattern.valid = hit;
   assign pattern.elems = elems;

endmodule

/* rtl/slot_timer.sv */
`timescale 1ns/1ps

module slot_timer #(
   parameter int SLOT_CYCLES = morse_pkg::DEFAULT_SLOT_CYCLES
) (
   input  logic clk,
   input  logic sw,
   output logic slot_tick
);

   import morse_pkg::*;

   localparam int CNT_W = (SLOT_CYCLES > 1) ? $clog2(SLOT_CYCLES) : 1;
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SLOT_CYCLES - 1);

   logic [CNT_W-1:0] cnt;

   assign slot_tick = (cnt == CNT_LAST); // last cycle of the slot

   always_ff @(posedge clk or posedge sw) begin
      if (sw) begin
         cnt <= '0;
      end
      else if (slot_tick) begin
         cnt <= '0;
      end
      else begin
         cnt <= cnt + 1'b1;
      end
   end

   // a slot longer than one clock never ticks back to back
   a_tick_single : assert property (
      @(posedge clk) disable iff (sw)
      ((SLOT_CYCLES > 1) && slot_tick) |=> !slot_tick
   ) else $error("slot_tick high in consecutive cycles");

endmodule

/* rtl/morse_sequencer.sv */
`timescale 1ns/1ps

module morse_sequencer (
   input  logic                      clk,
   input  logic                      sw,
   input  logic                      slot_tick,
   input  logic                      speed_dot,
   input  logic                      speed_dash,
   input  morse_pkg::char_code_t     code0,
   input  morse_pkg::char_code_t     code1,
   input  morse_pkg::char_code_t     code2,
   input  morse_pkg::char_code_t     code3,
   input  morse_pkg::char_code_t     code4,
   input  morse_pkg::char_code_t     code5,
   input  morse_pkg::char_code_t     code6,
   input  morse_pkg::char_code_t     code7,
   input  morse_pkg::morse_pattern_t pattern,
   output morse_pkg::char_code_t     cur_code,
   output logic                      key
);

   import morse_pkg::*;

   localparam logic [CHAR_IDX_W-1:0] CHAR_LAST = CHAR_IDX_W'(NUM_CHARS - 1);
   localparam logic [SLOT_IDX_W-1:0] SLOT_LAST = SLOT_IDX_W'(SLOTS_PER_CHAR - 1);
   localparam logic [SLOT_IDX_W-1:0] GAP_END   = SLOT_IDX_W'(GAP_SLOTS);
   localparam logic [SUB_IDX_W-1:0]  SUB_LAST  = SUB_IDX_W'(SLOTS_PER_ELEM - 1);
   localparam logic [SUB_IDX_W-1:0]  DOT_LAST  = SUB_IDX_W'(DOT_ON_SLOTS);
   localparam logic [SUB_IDX_W-1:0]  DASH_LAST = SUB_IDX_W'(DASH_ON_SLOTS);

   // position of the current slot
   logic [CHAR_IDX_W-1:0] char_idx;
   logic [SLOT_IDX_W-1:0] slot_idx;
   logic [ELEM_IDX_W-1:0] elem_idx;
   logic [SUB_IDX_W-1:0]  sub_idx;

   // position of the slot that follows
   logic [CHAR_IDX_W-1:0] char_nxt;
   logic [SLOT_IDX_W-1:0] slot_nxt;
   logic [ELEM_IDX_W-1:0] elem_nxt;
   logic [SUB_IDX_W-1:0]  sub_nxt;

   logic gap_nxt;
   logic elem_on;
   logic key_nxt;

   always_comb begin
      char_nxt = char_idx;
      slot_nxt = slot_idx + 1'b1;
      elem_nxt = elem_idx;
      sub_nxt  = sub_idx + 1'b1;
      if (slot_idx == SLOT_LAST) begin // character done
         slot_nxt = '0;
         elem_nxt = '0;
         sub_nxt  = '0;
         char_nxt = (char_idx == CHAR_LAST) ? '0 : char_idx + 1'b1;
      end
      else if (slot_idx < GAP_END) begin // elements start at zero after the gap
         elem_nxt = '0;
         sub_nxt  = '0;
      end
      else if (sub_idx == SUB_LAST) begin
         elem_nxt = elem_idx + 1'b1;
         sub_nxt  = '0;
      end
   end

   always_comb begin
      case (char_nxt)
         3'd0:    cur_code = code0;
         3'd1:    cur_code = code1;
         3'd2:    cur_code = code2;
         3'd3:    cur_code = code3;
         3'd4:    cur_code = code4;
         3'd5:    cur_code = code5;
         3'd6:    cur_code = code6;
         default: cur_code = code7;
      endcase
   end

   assign gap_nxt = (slot_nxt < GAP_END);

   always_comb begin
      if (pattern.elems[elem_nxt]) begin // dash
         elem_on = (sub_nxt < DASH_LAST) || ((sub_nxt == DASH_LAST) && speed_dash);
      end
      else begin
         elem_on = (sub_nxt < DOT_LAST) || ((sub_nxt == DOT_LAST) && speed_dot);
      end
      key_nxt = pattern.valid && !gap_nxt && elem_on;
   end

   always_ff @(posedge clk or posedge sw) begin
      if (sw) begin
         char_idx <= '0;
         slot_idx <= '0;
         elem_idx <= '0;
         sub_idx  <= '0;
         key      <= 1'b0; // slot 0 is a gap
      end
      else if (slot_tick) begin
         char_idx <= char_nxt;
         slot_idx <= slot_nxt;
         elem_idx <= elem_nxt;
         sub_idx  <= sub_nxt;
         key      <= key_nxt;
      end
   end

   a_gap_silent : assert property (
      @(posedge clk) disable iff (sw)
      (slot_idx < GAP_END) |-> !key
   ) else $error("key high during a gap slot");

endmodule

/* rtl/tone_gen.sv */
`timescale 1ns/1ps

module tone_gen #(
   parameter int HALF_PERIOD = morse_pkg::DEFAULT_HALF_PERIOD
) (
   input  logic clk,
   input  logic sw,
   input  logic key,
   output logic beep
);

   import morse_pkg::*;

   localparam int CNT_W = (HALF_PERIOD > 1) ? $clog2(HALF_PERIOD) : 1;
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(HALF_PERIOD - 1);

   logic [CNT_W-1:0] half_cnt;

   always_ff @(posedge clk or posedge sw) begin
      if (sw) begin
         half_cnt <= '0;
         beep     <= 1'b0;
      end
      else if (!key) begin // silent so the tone restarts low
         half_cnt <= '0;
         beep     <= 1'b0;
      end
      else if (half_cnt == CNT_LAST) begin
         half_cnt <= '0;
         beep     <= ~beep;
      end
      else begin
         half_cnt <= half_cnt + 1'b1;
      end
   end

   a_beep_quiet : assert property (
      @(posedge clk) disable iff (sw)
      !key |=> !beep
   ) else $error("beep high one cycle after key low");

endmodule

/* rtl/morse_beeper.sv */
`timescale 1ns/1ps

module morse_beeper #(
   parameter int SLOT_CYCLES = morse_pkg::DEFAULT_SLOT_CYCLES,
   parameter int HALF_PERIOD = morse_pkg::DEFAULT_HALF_PERIOD
) (
   input  logic                  clk,
   input  logic                  sw,
   input  logic                  speed_dot,
   input  logic                  speed_dash,
   input  morse_pkg::char_code_t code0,
   input  morse_pkg::char_code_t code1,
   input  morse_pkg::char_code_t code2,
   input  morse_pkg::char_code_t code3,
   input  morse_pkg::char_code_t code4,
   input  morse_pkg::char_code_t code5,
   input  morse_pkg::char_code_t code6,
   input  morse_pkg::char_code_t code7,
   output logic                  key,
   output logic                  beep
);

   import morse_pkg::*;

   logic           slot_tick;
   char_code_t     cur_code;
   morse_pattern_t pattern;

   slot_timer #(
      .SLOT_CYCLES (SLOT_CYCLES)
   ) i_slot_timer (
      .clk       (clk),
      .sw        (sw),
      .slot_tick (slot_tick)
   );

   morse_sequencer i_morse_sequencer (
      .clk        (clk),
      .sw         (sw),
      .slot_tick  (slot_tick),
      .speed_dot  (speed_dot),
      .speed_dash (speed_dash),
      .code0      (code0),
      .code1      (code1),
      .code2      (code2),
      .code3      (code3),
      .code4      (code4),
      .code5      (code5),
      .code6      (code6),
      .code7      (code7),
      .pattern    (pattern),
      .cur_code   (cur_code),
      .key        (key)
   );

   morse_char_rom i_morse_char_rom (
      .code    (cur_code),
      .pattern (pattern)
   );

   tone_gen #(
      .HALF_PERIOD (HALF_PERIOD)
   ) i_tone_gen (
      .clk  (clk),
      .sw   (sw),
      .key  (key),
      .beep (beep)
   );

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
   parameter real PERIOD_NS = 8.0
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
   end

   always #(PERIOD_NS / 2.0) clk = ~clk; // 125 MHz

endmodule

/* verification/tb_morse_beeper.sv */
`timescale 1ns/1ps

module tb_morse_beeper;

   localparam int SLOT_CYCLES    = 4;
   localparam int HALF_PERIOD    = 3;
   localparam int GAP_SLOTS      = 5;
   localparam int SLOTS_PER_ELEM = 5;
   localparam int SLOTS_PER_CHAR = 30;
   localparam int FRAME_SLOTS    = 240;
   localparam int FRAME_CYCLES   = FRAME_SLOTS * SLOT_CYCLES; // 960
   localparam int RUN_CYCLES     = 3 * FRAME_CYCLES;
   localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES;
   localparam int RESET_CYCLES   = 8;

   logic       clk;
   logic       sw;
   logic       speed_dot;
   logic       speed_dash;
   logic [5:0] code_in [8];
   logic       key;
   logic       beep;

   int seed;
   int cyc;
   int run_cycles = 0;
   int key_errs;
   int beep_errs;
   int other_errs;
   int n_valid;
   int n_invalid;
   int n_key_high;
   bit exp_key;
   bit exp_beep;
   int tone_run; // cycles key has been high so far

   tb_clock #(.PERIOD_NS(8.0)) i_tb_clock (.clk(clk));

   morse_beeper #(
      .SLOT_CYCLES (SLOT_CYCLES),
      .HALF_PERIOD (HALF_PERIOD)
   ) i_morse_beeper (
      .clk        (clk),
      .sw         (sw),
      .speed_dot  (speed_dot),
      .speed_dash (speed_dash),
      .code0      (code_in[0]),
      .code1      (code_in[1]),
      .code2      (code_in[2]),
      .code3      (code_in[3]),
      .code4      (code_in[4]),
      .code5      (code_in[5]),
      .code6      (code_in[6]),
      .code7      (code_in[7]),
      .key        (key),
      .beep       (beep)
   );

   // elements of a digit code as dots and dashes
   function automatic string code_elems(input logic [5:0] code);
      case (code)
         6'd36:   return "-----";
         6'd27:   return ".----";
         6'd28:   return "..---";
         6'd29:   return "...--";
         6'd30:   return "....-";
         6'd31:   return ".....";
         6'd35:   return "-....";
         6'd34:   return "--...";
         6'd33:   return "---..";
         6'd32:   return "----.";
         default: return "";
      endcase
   endfunction

   function automatic bit slot_key(input logic [5:0] code, input int sic,
                                   input bit dot_long, input bit dash_long);
      string els;
      int    e;
      int    sub;
      els = code_elems(code);
      if (sic < GAP_SLOTS || els.len() == 0) return 1'b0;
      e   = (sic - GAP_SLOTS) / SLOTS_PER_ELEM;
      sub = (sic - GAP_SLOTS) % SLOTS_PER_ELEM;
      if (els[e] == "-") return (sub < 3) || (sub == 3 && dash_long);
      return (sub == 0) || (sub == 1 && dot_long);
   endfunction

   function automatic int rand_below(input int n);
      int r;
      r = $random(seed) & 32'h7fff_ffff;
      return r % n;
   endfunction

   function automatic bit rand_bit();
      int r;
      r = $random(seed);
      return r[0];
   endfunction

   // digit codes are 27 to 36 and one pick in four is a junk code
   function automatic logic [5:0] pick_code();
      logic [5:0] c;
      if (rand_below(4) != 0) return 6'(27 + rand_below(10));
      c = 6'(rand_below(64));
      while (c >= 6'd27 && c <= 6'd36) c = 6'(rand_below(64));
      return c;
   endfunction

   task automatic check_outputs();
      assert (key === exp_key) else begin
         key_errs++;
         $display("mismatch key cycle %0d slot %0d: got %h expected %h",
                  cyc, cyc / SLOT_CYCLES, key, exp_key);
      end
      assert (beep === exp_beep) else begin
         beep_errs++;
         $display("mismatch beep cycle %0d: got %h expected %h", cyc, beep, exp_beep);
      end
      if (key === 1'b1) n_key_high++;
   endtask

   task automatic check_idle();
      assert (key === 1'b0) else begin
         key_errs++;
         $display("mismatch key in reset: got %h expected %h", key, 1'b0);
      end
      assert (beep === 1'b0) else begin
         beep_errs++;
         $display("mismatch beep in reset: got %h expected %h", beep, 1'b0);
      end
   endtask

   // model update at the edge that ends cycle cyc
   task automatic step_model();
      int nxt;
      int fs;
      nxt = cyc + 1;
      if (exp_key) tone_run++;
      else tone_run = 0;
      exp_beep = ((tone_run / HALF_PERIOD) % 2) == 1;
      if (nxt % SLOT_CYCLES == 0) begin
         fs = (nxt / SLOT_CYCLES) % FRAME_SLOTS;
         exp_key = slot_key(code_in[fs / SLOTS_PER_CHAR], fs % SLOTS_PER_CHAR,
                            speed_dot, speed_dash);
      end
   endtask

   task automatic drive_inputs();
      int         nxt;
      int         fs;
      logic [5:0] c;
      string      els;
      nxt = cyc + 1;
      fs  = (nxt / SLOT_CYCLES) % FRAME_SLOTS;
      if (nxt % SLOT_CYCLES == 0) begin // slot start
         speed_dot  <= rand_bit();
         speed_dash <= rand_bit();
      end
      if (nxt % SLOT_CYCLES == 2 && fs % SLOTS_PER_CHAR == 2) begin // mid gap
         c   = pick_code();
         els = code_elems(c);
         if (els.len() != 0) n_valid++;
         else n_invalid++;
         code_in[fs / SLOTS_PER_CHAR] <= c;
      end
   endtask

   initial begin
      seed       = 32'hbae9_0d2a;
      key_errs   = 0;
      beep_errs  = 0;
      other_errs = 0;
      n_valid    = 0;
      n_invalid  = 0;
      n_key_high = 0;
      exp_key    = 1'b0;
      exp_beep   = 1'b0;
      tone_run   = 0;
      cyc        = 0;
      sw         = 1'b1;
      speed_dot  = 1'b0;
      speed_dash = 1'b0;
      for (int i = 0; i < 8; i++) code_in[i] = pick_code();

      repeat (RESET_CYCLES - 1) begin
         @(posedge clk);
         @(negedge clk);
         check_idle();
      end
      @(posedge clk);
      sw <= 1'b0; // cycle 0 of slot 0 follows this edge

      for (cyc = 0; cyc < RUN_CYCLES; cyc++) begin
         @(negedge clk);
         check_outputs();
         @(posedge clk);
         step_model();
         drive_inputs();
      end

      assert (n_valid > 0 && n_invalid > 0) else begin
         other_errs++;
         $display("stimulus did not use both valid and invalid codes");
      end
      assert (n_key_high > 0) else begin
         other_errs++;
         $display("key never went high during the run");
      end

      $display("errors: key %0d, beep %0d, other %0d", key_errs, beep_errs, other_errs);
      if (key_errs + beep_errs + other_errs == 0) begin
         $display("=== PASS ===");
      end
      else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // guard against a stuck run
   always @(posedge clk) begin
      if (!sw) begin
         run_cycles <= run_cycles + 1;
         if (run_cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
         end
      end
   end

endmodule

/* flist.f */
rtl/morse_pkg.sv
rtl/morse_char_rom.sv
rtl/slot_timer.sv
rtl/morse_sequencer.sv
rtl/tone_gen.sv
rtl/morse_beeper.sv
verification/tb_clock.sv
verification/tb_morse_beeper.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the Morse beacon testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   -f flist.f \
   --top-module tb_morse_beeper \
   -o tb_morse_beeper

status=0
out=$(./obj_dir/tb_morse_beeper) || status=$?
echo "$out"

if grep -q "=== PASS ===" <<< "$out"; then
   exit 0
fi
echo "simulation did not pass (exit status $status)"
exit 1
